// ==== src/ccc_pkg.sv ====
// CCC handler constants, command codes and the packed bus and configuration types
package ccc_pkg;

  // Command code and bus byte width
  localparam int CccW   = 8;
  // Target address width
  localparam int AddrW  = 7;
  // Data and response byte counters
  localparam int CountW = 8;

  // I3C broadcast address
  localparam logic [AddrW-1:0] RsvdAddr     = 7'h7E;
  // Third GETMRL byte, max IBI payload
  localparam logic [CccW-1:0]  GetMrlIbiMax = 8'hFF;

  // Broadcast codes, top bit clear
  localparam logic [CccW-1:0] CccBcastEnec    = 8'h00;
  localparam logic [CccW-1:0] CccBcastDisec   = 8'h01;
  localparam logic [CccW-1:0] CccBcastRstdaa  = 8'h06;
  localparam logic [CccW-1:0] CccBcastSetmwl  = 8'h09;
  localparam logic [CccW-1:0] CccBcastSetmrl  = 8'h0A;
  localparam logic [CccW-1:0] CccBcastSetaasa = 8'h29;

  // Direct codes, top bit set
  localparam logic [CccW-1:0] CccDirectEnec      = 8'h80;
  localparam logic [CccW-1:0] CccDirectDisec     = 8'h81;
  localparam logic [CccW-1:0] CccDirectSetdasa   = 8'h87;
  localparam logic [CccW-1:0] CccDirectSetmwl    = 8'h89;
  localparam logic [CccW-1:0] CccDirectSetmrl    = 8'h8A;
  localparam logic [CccW-1:0] CccDirectGetmwl    = 8'h8B;
  localparam logic [CccW-1:0] CccDirectGetmrl    = 8'h8C;
  localparam logic [CccW-1:0] CccDirectGetpid    = 8'h8D;
  localparam logic [CccW-1:0] CccDirectGetbcr    = 8'h8E;
  localparam logic [CccW-1:0] CccDirectGetdcr    = 8'h8F;
  localparam logic [CccW-1:0] CccDirectGetstatus = 8'h90;

  // Bus monitor flags
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_cond_t;

  // Received bit or byte, bit value in rx_data[7]
  typedef struct packed {
    logic            rx_done;
    logic [CccW-1:0] rx_data;
  } bus_rx_t;

  typedef struct packed {
    logic req_bit;
    logic req_byte;
  } bus_rx_req_t;

  // Transmit request, bit value in value[0]
  typedef struct packed {
    logic            req_byte;
    logic            req_bit;
    logic [CccW-1:0] value;
    logic            sel_od_pp;
  } bus_tx_req_t;

  // Own addresses with their valid flags
  typedef struct packed {
    logic [AddrW-1:0] sta_addr;
    logic             sta_valid;
    logic [AddrW-1:0] dyn_addr;
    logic             dyn_valid;
  } target_addr_t;

  // Device information served by the GETs
  typedef struct packed {
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic [47:0] pid;
    logic [15:0] status;
  } dev_info_t;

  // Configuration outputs, set_* and rstdaa are one-cycle pulses
  typedef struct packed {
    logic             set_mwl;
    logic [15:0]      mwl;
    logic             set_mrl;
    logic [15:0]      mrl;
    logic             enec_ibi;
    logic             enec_crr;
    logic             enec_hj;
    logic             disec_ibi;
    logic             disec_crr;
    logic             disec_hj;
    logic             rstdaa;
    logic             set_dasa_valid;
    logic [AddrW-1:0] set_dasa;
  } ccc_cfg_t;

  // Frame sequencer strobes to the capture, SET and GET blocks
  typedef struct packed {
    logic addr_capture;
    logic data_capture;
    logic data_commit;
    logic code_tbit_done;
    logic get_load;
    logic get_next;
  } ccc_strobe_t;

endpackage

// ==== src/ccc_rx_capture.sv ====
// Input side of the CCC handler, holds code, direct address and data bytes for the sequencer
`timescale 1ns/1ps

module ccc_rx_capture (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [ccc_pkg::CccW-1:0]   ccc_i,
  input  logic                       ccc_valid_i,
  input  ccc_pkg::bus_rx_t           bus_rx_i,
  input  ccc_pkg::target_addr_t      target_addr_i,
  input  ccc_pkg::ccc_strobe_t       strobe_i,
  output logic [ccc_pkg::CccW-1:0]   code_o,
  output logic                       rnw_o,
  output logic                       addr_match_o,
  output logic                       rsvd_addr_o,
  output logic [ccc_pkg::CccW-1:0]   last_byte_o,
  output logic [ccc_pkg::CountW-1:0] byte_count_o
);

  logic [ccc_pkg::AddrW-1:0] addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_o       <= '0;
      addr_q       <= '0;
      rnw_o        <= 1'b0;
      last_byte_o  <= '0;
      byte_count_o <= '0;
    end else begin
      // New code drops the address of the previous frame
      if (ccc_valid_i) begin
        code_o       <= ccc_i;
        addr_q       <= '0;
        rnw_o        <= 1'b0;
        byte_count_o <= '0;
      end else if (strobe_i.addr_capture) begin
        addr_q       <= bus_rx_i.rx_data[7:1];
        rnw_o        <= bus_rx_i.rx_data[0];
        byte_count_o <= '0;
      end else if (strobe_i.data_commit) begin
        // Counts bytes whose T-bit is in
        byte_count_o <= byte_count_o + 1'b1;
      end
      if (strobe_i.data_capture) begin
        last_byte_o <= bus_rx_i.rx_data;
      end
    end
  end

  // Dynamic address wins over static
  always_comb begin
    if (target_addr_i.dyn_valid) begin
      addr_match_o = (addr_q == target_addr_i.dyn_addr);
    end else if (target_addr_i.sta_valid) begin
      addr_match_o = (addr_q == target_addr_i.sta_addr);
    end else begin
      addr_match_o = 1'b0;
    end
  end

  assign rsvd_addr_o = (addr_q == ccc_pkg::RsvdAddr);

endmodule

// ==== src/ccc_frame_seq.sv ====
// Processing part of the CCC handler, walks the frame and drives bus requests and strobes
`timescale 1ns/1ps

module ccc_frame_seq (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     ccc_valid_i,
  input  ccc_pkg::bus_cond_t       bus_cond_i,
  input  ccc_pkg::bus_rx_t         bus_rx_i,
  input  logic                     bus_tx_done_i,
  input  logic [ccc_pkg::CccW-1:0] code_i,
  input  logic                     rnw_i,
  input  logic                     addr_match_i,
  input  logic                     rsvd_addr_i,
  input  logic [ccc_pkg::CccW-1:0] tx_byte_i,
  input  logic                     tx_last_i,
  output ccc_pkg::bus_rx_req_t     rx_req_o,
  output ccc_pkg::bus_tx_req_t     tx_req_o,
  output ccc_pkg::ccc_strobe_t     strobe_o,
  output logic                     done_o
);

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxCodeTbit,
    SkipByte,
    SkipTbit,
    RxAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitRstart,
    WaitStop,
    Done
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   rx_done;
  logic   rstart;

  assign rx_done = bus_rx_i.rx_done;
  assign rstart  = bus_cond_i.rstart;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:       state_d = WaitCcc;
      WaitCcc:    if (ccc_valid_i) state_d = RxCodeTbit;
      // Top bit of the code selects direct
      RxCodeTbit: if (rx_done) state_d = code_i[7] ? SkipByte : RxData;
      SkipByte: begin
        if (rstart) state_d = RxAddr;
        else if (rx_done) state_d = SkipTbit;
      end
      SkipTbit:   if (rx_done) state_d = SkipByte;
      RxAddr:     if (rx_done) state_d = TxAddrAck;
      TxAddrAck: begin
        if (bus_tx_done_i) begin
          if (rsvd_addr_i) state_d = WaitStop;
          else if (addr_match_i) state_d = rnw_i ? TxData : RxData;
          else state_d = WaitRstart;
        end
      end
      RxData: begin
        if (rstart) state_d = RxAddr;
        else if (rx_done) state_d = RxDataTbit;
      end
      RxDataTbit: if (rx_done) state_d = RxData;
      TxData: begin
        if (rstart) state_d = RxAddr;
        else if (bus_tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit: if (bus_tx_done_i) state_d = tx_last_i ? WaitRstart : TxData;
      WaitRstart: if (rstart) state_d = RxAddr;
      // Only STOP leaves
      WaitStop:   state_d = WaitStop;
      Done:       state_d = Idle;
      default:    state_d = Idle;
    endcase
  end

  // Requests are held for the whole state, a Repeated Start drops a pending byte
  always_comb begin
    rx_req_o = '0;
    tx_req_o = '0;
    case (state_q)
      RxCodeTbit, SkipTbit, RxDataTbit: rx_req_o.req_bit = 1'b1;
      RxAddr:   rx_req_o.req_byte = 1'b1;
      SkipByte, RxData: rx_req_o.req_byte = !rstart;
      TxAddrAck: begin
        // ACK low on match, open drain
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = {{(ccc_pkg::CccW-1){1'b0}}, !addr_match_i};
      end
      TxData: begin
        tx_req_o.req_byte  = 1'b1;
        tx_req_o.value     = tx_byte_i;
        tx_req_o.sel_od_pp = 1'b1;
      end
      TxDataTbit: begin
        // T-bit high while bytes remain
        tx_req_o.req_bit   = 1'b1;
        tx_req_o.value     = {{(ccc_pkg::CccW-1){1'b0}}, !tx_last_i};
        tx_req_o.sel_od_pp = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    strobe_o                = '0;
    strobe_o.code_tbit_done = (state_q == RxCodeTbit) && rx_done;
    strobe_o.addr_capture   = (state_q == RxAddr) && rx_done;
    strobe_o.data_capture   = (state_q == RxData) && rx_done && !rstart;
    strobe_o.data_commit    = (state_q == RxDataTbit) && rx_done;
    // Length loads once the ACK is out
    strobe_o.get_load       = (state_q == TxAddrAck) && bus_tx_done_i;
    strobe_o.get_next       = (state_q == TxData) && bus_tx_done_i;
  end

  assign done_o = (state_q == Done);

  // STOP overrides every state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (bus_cond_i.stop) begin
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== src/ccc_set_handler.sv ====
// Output side of the CCC handler, turns committed SET bytes into configuration registers
`timescale 1ns/1ps

module ccc_set_handler (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ccc_pkg::ccc_strobe_t       strobe_i,
  input  logic [ccc_pkg::CccW-1:0]   code_i,
  input  logic [ccc_pkg::CccW-1:0]   last_byte_i,
  input  logic [ccc_pkg::CountW-1:0] byte_count_i,
  input  logic                       rsvd_addr_i,
  input  ccc_pkg::target_addr_t      target_addr_i,
  output ccc_pkg::ccc_cfg_t          cfg_o
);

  logic commit;
  logic first;
  logic second;

  // Frames addressed to 7E are ignored
  assign commit = strobe_i.data_commit && !rsvd_addr_i;
  assign first  = (byte_count_i == '0);
  assign second = (byte_count_i == ccc_pkg::CountW'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_o <= '0;
    end else begin
      // Pulses last one cycle
      cfg_o.set_mwl        <= 1'b0;
      cfg_o.set_mrl        <= 1'b0;
      cfg_o.rstdaa         <= 1'b0;
      cfg_o.set_dasa_valid <= 1'b0;
      if (commit) begin
        case (code_i)
          // MSB first, pulse with the low byte
          ccc_pkg::CccBcastSetmwl, ccc_pkg::CccDirectSetmwl: begin
            if (first) begin
              cfg_o.mwl[15:8] <= last_byte_i;
            end else if (second) begin
              cfg_o.mwl[7:0] <= last_byte_i;
              cfg_o.set_mwl  <= 1'b1;
            end
          end
          ccc_pkg::CccBcastSetmrl, ccc_pkg::CccDirectSetmrl: begin
            if (first) begin
              cfg_o.mrl[15:8] <= last_byte_i;
            end else if (second) begin
              cfg_o.mrl[7:0] <= last_byte_i;
              cfg_o.set_mrl  <= 1'b1;
            end
          end
          // Event bits: 0 IBI, 1 CRR, 3 hot-join
          ccc_pkg::CccBcastEnec, ccc_pkg::CccDirectEnec: begin
            if (first) begin
              cfg_o.enec_ibi <= last_byte_i[0];
              cfg_o.enec_crr <= last_byte_i[1];
              cfg_o.enec_hj  <= last_byte_i[3];
            end
          end
          ccc_pkg::CccBcastDisec, ccc_pkg::CccDirectDisec: begin
            if (first) begin
              cfg_o.disec_ibi <= last_byte_i[0];
              cfg_o.disec_crr <= last_byte_i[1];
              cfg_o.disec_hj  <= last_byte_i[3];
            end
          end
          // Address in the upper seven bits
          ccc_pkg::CccDirectSetdasa: begin
            if (first) begin
              cfg_o.set_dasa       <= last_byte_i[7:1];
              cfg_o.set_dasa_valid <= 1'b1;
            end
          end
          default: ;
        endcase
      end
      // Data-less broadcasts act on their T-bit
      if (strobe_i.code_tbit_done) begin
        if (code_i == ccc_pkg::CccBcastRstdaa) begin
          cfg_o.rstdaa <= 1'b1;
        end else if (code_i == ccc_pkg::CccBcastSetaasa) begin
          cfg_o.set_dasa       <= target_addr_i.sta_addr;
          cfg_o.set_dasa_valid <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/ccc_get_responder.sv ====
// Output side of the CCC handler, supplies the GET response bytes to the sequencer
`timescale 1ns/1ps

module ccc_get_responder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ccc_pkg::ccc_strobe_t     strobe_i,
  input  logic [ccc_pkg::CccW-1:0] code_i,
  input  ccc_pkg::dev_info_t       dev_info_i,
  output logic [ccc_pkg::CccW-1:0] tx_byte_o,
  output logic                     tx_last_o
);

  // Bytes still to send
  logic [ccc_pkg::CountW-1:0] count_q;
  logic [ccc_pkg::CountW-1:0] len;
  // Response right aligned, last byte in the low bits
  logic [6*ccc_pkg::CccW-1:0] resp;
  logic [6*ccc_pkg::CccW-1:0] resp_shift;

  always_comb begin
    len  = '0;
    resp = '0;
    case (code_i)
      ccc_pkg::CccDirectGetbcr: begin
        len  = ccc_pkg::CountW'(1);
        resp = dev_info_i.bcr;
      end
      ccc_pkg::CccDirectGetdcr: begin
        len  = ccc_pkg::CountW'(1);
        resp = dev_info_i.dcr;
      end
      ccc_pkg::CccDirectGetmwl: begin
        len  = ccc_pkg::CountW'(2);
        resp = dev_info_i.mwl;
      end
      // Format 1 only
      ccc_pkg::CccDirectGetstatus: begin
        len  = ccc_pkg::CountW'(2);
        resp = dev_info_i.status;
      end
      ccc_pkg::CccDirectGetmrl: begin
        len  = ccc_pkg::CountW'(3);
        resp = {dev_info_i.mrl, ccc_pkg::GetMrlIbiMax};
      end
      ccc_pkg::CccDirectGetpid: begin
        len  = ccc_pkg::CountW'(6);
        resp = dev_info_i.pid;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (strobe_i.get_load) begin
      count_q <= len;
    end else if (strobe_i.get_next && count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // MSB first, byte at position count-1
  assign resp_shift = resp >> {count_q - 1'b1, 3'b000};
  assign tx_byte_o  = (count_q == '0) ? '0 : resp_shift[ccc_pkg::CccW-1:0];
  // Nothing left after the byte just sent
  assign tx_last_o  = (count_q == '0);

endmodule

// ==== src/ccc_top.sv ====
// Top level of the I3C target CCC handler, connects capture, sequencer, SET and GET blocks
`timescale 1ns/1ps

module ccc_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [ccc_pkg::CccW-1:0] ccc_i,
  input  logic                     ccc_valid_i,
  input  ccc_pkg::bus_cond_t       bus_cond_i,
  input  ccc_pkg::bus_rx_t         bus_rx_i,
  input  logic                     bus_tx_done_i,
  input  ccc_pkg::target_addr_t    target_addr_i,
  input  ccc_pkg::dev_info_t       dev_info_i,
  output ccc_pkg::bus_rx_req_t     rx_req_o,
  output ccc_pkg::bus_tx_req_t     tx_req_o,
  output ccc_pkg::ccc_cfg_t        cfg_o,
  output logic                     done_o
);

  // Capture results
  logic [ccc_pkg::CccW-1:0]   code;
  logic                       rnw;
  logic                       addr_match;
  logic                       rsvd_addr;
  logic [ccc_pkg::CccW-1:0]   last_byte;
  logic [ccc_pkg::CountW-1:0] byte_count;
  // Sequencer strobes and GET byte
  ccc_pkg::ccc_strobe_t       strobe;
  logic [ccc_pkg::CccW-1:0]   tx_byte;
  logic                       tx_last;

  ccc_rx_capture u_rx_capture (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ccc_i        (ccc_i),
    .ccc_valid_i  (ccc_valid_i),
    .bus_rx_i     (bus_rx_i),
    .target_addr_i(target_addr_i),
    .strobe_i     (strobe),
    .code_o       (code),
    .rnw_o        (rnw),
    .addr_match_o (addr_match),
    .rsvd_addr_o  (rsvd_addr),
    .last_byte_o  (last_byte),
    .byte_count_o (byte_count)
  );

  ccc_frame_seq u_frame_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ccc_valid_i  (ccc_valid_i),
    .bus_cond_i   (bus_cond_i),
    .bus_rx_i     (bus_rx_i),
    .bus_tx_done_i(bus_tx_done_i),
    .code_i       (code),
    .rnw_i        (rnw),
    .addr_match_i (addr_match),
    .rsvd_addr_i  (rsvd_addr),
    .tx_byte_i    (tx_byte),
    .tx_last_i    (tx_last),
    .rx_req_o     (rx_req_o),
    .tx_req_o     (tx_req_o),
    .strobe_o     (strobe),
    .done_o       (done_o)
  );

  ccc_set_handler u_set_handler (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .strobe_i     (strobe),
    .code_i       (code),
    .last_byte_i  (last_byte),
    .byte_count_i (byte_count),
    .rsvd_addr_i  (rsvd_addr),
    .target_addr_i(target_addr_i),
    .cfg_o        (cfg_o)
  );

  ccc_get_responder u_get_responder (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .strobe_i  (strobe),
    .code_i    (code),
    .dev_info_i(dev_info_i),
    .tx_byte_o (tx_byte),
    .tx_last_o (tx_last)
  );

endmodule

// ==== testbench/tb_ccc_ref.svh ====
// Reference model, random source and typed compare tasks, included into the CCC handler testbench
`ifndef TB_CCC_REF_SVH
`define TB_CCC_REF_SVH

// Galois LFSR, taps of x^32+x^22+x^2+x+1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r      = {r[30:0], lfsr_q[0]};
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
  end
  return r;
endfunction

// Bus layer answers after 1 to 4 cycles
function automatic int bus_delay();
  return 1 + int'(rand_bits(2));
endfunction

// GET response length per command code
function automatic int get_len(input logic [ccc_pkg::CccW-1:0] code);
  case (code)
    ccc_pkg::CccDirectGetbcr, ccc_pkg::CccDirectGetdcr:    return 1;
    ccc_pkg::CccDirectGetmwl, ccc_pkg::CccDirectGetstatus: return 2;
    ccc_pkg::CccDirectGetmrl:                              return 3;
    ccc_pkg::CccDirectGetpid:                              return 6;
    default:                                               return 0;
  endcase
endfunction

// Byte idx of a GET response, most significant byte first
function automatic logic [ccc_pkg::CccW-1:0] get_byte(input logic [ccc_pkg::CccW-1:0] code,
                                                       input ccc_pkg::dev_info_t info,
                                                       input int idx);
  case (code)
    ccc_pkg::CccDirectGetbcr:    return info.bcr;
    ccc_pkg::CccDirectGetdcr:    return info.dcr;
    ccc_pkg::CccDirectGetmwl:    return (idx == 0) ? info.mwl[15:8] : info.mwl[7:0];
    ccc_pkg::CccDirectGetstatus: return (idx == 0) ? info.status[15:8] : info.status[7:0];
    ccc_pkg::CccDirectGetmrl: begin
      if (idx == 0) return info.mrl[15:8];
      if (idx == 1) return info.mrl[7:0];
      // Max IBI payload byte
      return 8'hFF;
    end
    ccc_pkg::CccDirectGetpid:    return info.pid[8*(5-idx) +: 8];
    default:                     return 8'h00;
  endcase
endfunction

// Configuration in the cycle after a SET commits, pulses set
function automatic ccc_pkg::ccc_cfg_t expected_cfg(input ccc_pkg::ccc_cfg_t prev,
                                                   input logic [ccc_pkg::CccW-1:0] code,
                                                   input logic [7:0] b0,
                                                   input logic [7:0] b1,
                                                   input logic [ccc_pkg::AddrW-1:0] sta);
  ccc_pkg::ccc_cfg_t c;
  c                = prev;
  c.set_mwl        = 1'b0;
  c.set_mrl        = 1'b0;
  c.rstdaa         = 1'b0;
  c.set_dasa_valid = 1'b0;
  case (code)
    ccc_pkg::CccBcastSetmwl, ccc_pkg::CccDirectSetmwl: begin
      c.mwl     = {b0, b1};
      c.set_mwl = 1'b1;
    end
    ccc_pkg::CccBcastSetmrl, ccc_pkg::CccDirectSetmrl: begin
      c.mrl     = {b0, b1};
      c.set_mrl = 1'b1;
    end
    ccc_pkg::CccBcastEnec, ccc_pkg::CccDirectEnec: begin
      c.enec_ibi = b0[0];
      c.enec_crr = b0[1];
      c.enec_hj  = b0[3];
    end
    ccc_pkg::CccBcastDisec, ccc_pkg::CccDirectDisec: begin
      c.disec_ibi = b0[0];
      c.disec_crr = b0[1];
      c.disec_hj  = b0[3];
    end
    ccc_pkg::CccDirectSetdasa: begin
      c.set_dasa       = b0[7:1];
      c.set_dasa_valid = 1'b1;
    end
    ccc_pkg::CccBcastSetaasa: begin
      c.set_dasa       = sta;
      c.set_dasa_valid = 1'b1;
    end
    ccc_pkg::CccBcastRstdaa: c.rstdaa = 1'b1;
    default: ;
  endcase
  return c;
endfunction

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
  end
endtask

task automatic check_byte(input string name, input logic [ccc_pkg::CccW-1:0] got,
                          input logic [ccc_pkg::CccW-1:0] exp);
  if (got !== exp) begin
    report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
  end
endtask

task automatic check_rx_req(input ccc_pkg::bus_rx_req_t got, input ccc_pkg::bus_rx_req_t exp);
  if (got !== exp) begin
    report_failure($sformatf("FAIL rx_req_o got %h expected %h", got, exp));
  end
endtask

task automatic check_tx_req(input ccc_pkg::bus_tx_req_t got, input ccc_pkg::bus_tx_req_t exp);
  if (got !== exp) begin
    report_failure($sformatf("FAIL tx_req_o got %h expected %h", got, exp));
  end
endtask

task automatic check_cfg(input ccc_pkg::ccc_cfg_t got, input ccc_pkg::ccc_cfg_t exp);
  if (got !== exp) begin
    report_failure($sformatf("FAIL cfg_o got %h expected %h", got, exp));
  end
endtask

`endif

// ==== testbench/tb_ccc_top.sv ====
// Testbench for the CCC handler, models the bus layer and checks GET, SET and STOP frames
`timescale 1ns/1ps

module tb_ccc_top;

  logic                     clk_i;
  logic                     rst_ni;
  logic [ccc_pkg::CccW-1:0] ccc_i;
  logic                     ccc_valid_i;
  ccc_pkg::bus_cond_t       bus_cond_i;
  ccc_pkg::bus_rx_t         bus_rx_i;
  logic                     bus_tx_done_i;
  ccc_pkg::target_addr_t    target_addr_i;
  ccc_pkg::dev_info_t       dev_info_i;
  ccc_pkg::bus_rx_req_t     rx_req_o;
  ccc_pkg::bus_tx_req_t     tx_req_o;
  ccc_pkg::ccc_cfg_t        cfg_o;
  logic                     done_o;

  // Random state, expected configuration and pending transmit requests
  logic [31:0]              lfsr_q;
  ccc_pkg::ccc_cfg_t        held_cfg;
  ccc_pkg::bus_tx_req_t     tx_expect_q[$];
  ccc_pkg::bus_tx_req_t     tx_exp;
  ccc_pkg::bus_rx_req_t     bit_req;
  ccc_pkg::bus_rx_req_t     byte_req;
  ccc_pkg::target_addr_t    home_addr;

  `include "tb_ccc_ref.svh"

  ccc_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ccc_i        (ccc_i),
    .ccc_valid_i  (ccc_valid_i),
    .bus_cond_i   (bus_cond_i),
    .bus_rx_i     (bus_rx_i),
    .bus_tx_done_i(bus_tx_done_i),
    .target_addr_i(target_addr_i),
    .dev_info_i   (dev_info_i),
    .rx_req_o     (rx_req_o),
    .tx_req_o     (tx_req_o),
    .cfg_o        (cfg_o),
    .done_o       (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic ccc_pkg::bus_tx_req_t tx_data_req(input logic [ccc_pkg::CccW-1:0] b);
    ccc_pkg::bus_tx_req_t r;
    r           = '0;
    r.req_byte  = 1'b1;
    r.value     = b;
    r.sel_od_pp = 1'b1;
    return r;
  endfunction

  // Bit value rides in value[0]
  function automatic ccc_pkg::bus_tx_req_t tx_bit_req(input logic v, input logic pp);
    ccc_pkg::bus_tx_req_t r;
    r           = '0;
    r.req_bit   = 1'b1;
    r.value[0]  = v;
    r.sel_od_pp = pp;
    return r;
  endfunction

  function automatic logic [ccc_pkg::AddrW-1:0] own_addr();
    return target_addr_i.dyn_valid ? target_addr_i.dyn_addr : target_addr_i.sta_addr;
  endfunction

  // All driving tasks start and end 10 ns after a rising edge
  task automatic send_code(input logic [ccc_pkg::CccW-1:0] code);
    ccc_i       = code;
    ccc_valid_i = 1'b1;
    @(posedge clk_i);
    #10;
    ccc_valid_i = 1'b0;
  endtask

  // Also proves nothing is being sent while waiting for Sr
  task automatic pulse_rstart();
    @(negedge clk_i);
    check_tx_req(tx_req_o, '0);
    @(posedge clk_i);
    #10;
    bus_cond_i.rstart = 1'b1;
    @(posedge clk_i);
    #10;
    bus_cond_i.rstart = 1'b0;
  endtask

  // Bus layer receive side
  task automatic serve_rx(input ccc_pkg::bus_rx_req_t exp, input logic [ccc_pkg::CccW-1:0] data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (rx_req_o == '0) begin
      if (waited == 40) begin
        report_failure("Timed out waiting for a receive request from the DUT");
      end
      waited++;
      @(negedge clk_i);
    end
    check_rx_req(rx_req_o, exp);
    repeat (bus_delay()) @(posedge clk_i);
    #10;
    bus_rx_i.rx_done = 1'b1;
    bus_rx_i.rx_data = data;
    @(posedge clk_i);
    #10;
    bus_rx_i = '0;
  endtask

  // Bus layer transmit side
  task automatic serve_tx(input ccc_pkg::bus_tx_req_t exp);
    int waited;
    waited = 0;
    tx_expect_q.push_back(exp);
    @(negedge clk_i);
    while (!(tx_req_o.req_bit || tx_req_o.req_byte)) begin
      if (waited == 40) begin
        report_failure("Timed out waiting for a transmit request from the DUT");
      end
      waited++;
      @(negedge clk_i);
    end
    repeat (bus_delay()) @(posedge clk_i);
    #10;
    bus_tx_done_i = 1'b1;
    @(posedge clk_i);
    #10;
    bus_tx_done_i = 1'b0;
  endtask

  // Sr, address byte, then the ACK bit in open drain
  task automatic address_target(input logic [ccc_pkg::AddrW-1:0] addr, input logic rnw,
                                input logic ack);
    pulse_rstart();
    serve_rx(byte_req, {addr, rnw});
    serve_tx(tx_bit_req(!ack, 1'b0));
  endtask

  task automatic serve_response(input logic [ccc_pkg::CccW-1:0] code);
    int len;
    len = get_len(code);
    for (int i = 0; i < len; i++) begin
      serve_tx(tx_data_req(get_byte(code, dev_info_i, i)));
      // T-bit high while another byte follows
      serve_tx(tx_bit_req(i < len - 1, 1'b1));
    end
  endtask

  task automatic send_stop();
    @(posedge clk_i);
    #10;
    bus_cond_i.stop = 1'b1;
    @(negedge clk_i);
    check_flag("done_o", done_o, 1'b0);
    @(posedge clk_i);
    #10;
    bus_cond_i.stop = 1'b0;
    // Done for exactly one cycle
    @(negedge clk_i);
    check_flag("done_o", done_o, 1'b1);
    @(posedge clk_i);
    #10;
    @(negedge clk_i);
    check_flag("done_o", done_o, 1'b0);
    check_rx_req(rx_req_o, '0);
    check_tx_req(tx_req_o, '0);
    check_cfg(cfg_o, held_cfg);
    // Idle now, accepting a code from the next cycle on
    @(posedge clk_i);
    #10;
  endtask

  task automatic run_get(input logic [ccc_pkg::CccW-1:0] code);
    send_code(code);
    serve_rx(bit_req, 8'h00);
    address_target(own_addr(), 1'b1, 1'b1);
    serve_response(code);
    send_stop();
  endtask

  task automatic run_set(input logic [ccc_pkg::CccW-1:0] code, input int nbytes);
    logic [7:0]        b0;
    logic [7:0]        b1;
    ccc_pkg::ccc_cfg_t exp;
    b0  = 8'(rand_bits(8));
    b1  = 8'(rand_bits(8));
    exp = expected_cfg(held_cfg, code, b0, b1, target_addr_i.sta_addr);
    send_code(code);
    serve_rx(bit_req, 8'h00);
    if (code[7]) begin
      address_target(own_addr(), 1'b0, 1'b1);
    end
    if (nbytes > 0) begin
      serve_rx(byte_req, b0);
      serve_rx(bit_req, 8'h00);
    end
    if (nbytes > 1) begin
      serve_rx(byte_req, b1);
      serve_rx(bit_req, 8'h00);
    end
    // Pulses are up in the cycle after the last commit
    @(negedge clk_i);
    check_cfg(cfg_o, exp);
    // Unused code keeps values and drops the pulses
    held_cfg = expected_cfg(exp, 8'hFF, 8'h00, 8'h00, '0);
    send_stop();
  endtask

  // Each transmit request is compared mid-cycle while done is high
  always @(negedge clk_i) begin
    if (bus_tx_done_i === 1'b1) begin
      tx_exp = tx_expect_q.pop_front();
      if (tx_exp.req_byte) begin
        check_byte("tx_req_o.value", tx_req_o.value, tx_exp.value);
      end
      check_tx_req(tx_req_o, tx_exp);
    end
  end

  initial begin
    rst_ni             = 1'b0;
    ccc_i              = '0;
    ccc_valid_i        = 1'b0;
    bus_cond_i         = '0;
    bus_rx_i           = '0;
    bus_tx_done_i      = 1'b0;
    lfsr_q             = 32'h9b8f;
    held_cfg           = '0;
    bit_req            = '0;
    bit_req.req_bit    = 1'b1;
    byte_req           = '0;
    byte_req.req_byte  = 1'b1;
    home_addr          = '0;
    home_addr.sta_addr = 7'h2A;
    home_addr.sta_valid = 1'b1;
    home_addr.dyn_addr = 7'h35;
    home_addr.dyn_valid = 1'b1;
    target_addr_i      = home_addr;
    // Random device information
    dev_info_i.bcr        = 8'(rand_bits(8));
    dev_info_i.dcr        = 8'(rand_bits(8));
    dev_info_i.mwl        = 16'(rand_bits(16));
    dev_info_i.mrl        = 16'(rand_bits(16));
    dev_info_i.pid[47:32] = 16'(rand_bits(16));
    dev_info_i.pid[31:0]  = rand_bits(32);
    dev_info_i.status     = 16'(rand_bits(16));
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_cfg(cfg_o, held_cfg);
    check_rx_req(rx_req_o, '0);
    check_tx_req(tx_req_o, '0);
    check_flag("done_o", done_o, 1'b0);
    @(posedge clk_i);
    #10;

    // Direct GETs to the dynamic address
    run_get(ccc_pkg::CccDirectGetpid);
    run_get(ccc_pkg::CccDirectGetbcr);
    run_get(ccc_pkg::CccDirectGetdcr);
    run_get(ccc_pkg::CccDirectGetmwl);
    run_get(ccc_pkg::CccDirectGetmrl);
    run_get(ccc_pkg::CccDirectGetstatus);

    // NACK to a foreign address and service after the next Sr
    send_code(ccc_pkg::CccDirectGetdcr);
    serve_rx(bit_req, 8'h00);
    address_target(7'h11, 1'b1, 1'b0);
    address_target(own_addr(), 1'b1, 1'b1);
    serve_response(ccc_pkg::CccDirectGetdcr);
    send_stop();

    // SETs in broadcast and direct form
    run_set(ccc_pkg::CccBcastSetmwl, 2);
    run_set(ccc_pkg::CccDirectSetmwl, 2);
    run_set(ccc_pkg::CccBcastSetmrl, 2);
    run_set(ccc_pkg::CccDirectSetmrl, 2);
    run_set(ccc_pkg::CccBcastEnec, 1);
    run_set(ccc_pkg::CccDirectEnec, 1);
    run_set(ccc_pkg::CccBcastDisec, 1);
    run_set(ccc_pkg::CccDirectDisec, 1);

    // SETDASA goes to the static address
    target_addr_i.dyn_valid = 1'b0;
    run_set(ccc_pkg::CccDirectSetdasa, 1);
    run_set(ccc_pkg::CccBcastSetaasa, 0);
    target_addr_i = home_addr;
    run_set(ccc_pkg::CccBcastRstdaa, 0);

    // STOP while a GETPID byte is still held
    send_code(ccc_pkg::CccDirectGetpid);
    serve_rx(bit_req, 8'h00);
    address_target(own_addr(), 1'b1, 1'b1);
    serve_tx(tx_data_req(get_byte(ccc_pkg::CccDirectGetpid, dev_info_i, 0)));
    serve_tx(tx_bit_req(1'b1, 1'b1));
    send_stop();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+testbench
src/ccc_pkg.sv
src/ccc_rx_capture.sv
src/ccc_frame_seq.sv
src/ccc_set_handler.sv
src/ccc_get_responder.sv
src/ccc_top.sv
testbench/tb_ccc_top.sv
